// ==== common/revo_config.svh ====
`ifndef REVO_CONFIG_SVH
`define REVO_CONFIG_SVH

// ------------------------------------------------------------
// event buffering
// ------------------------------------------------------------

// queued revo events before overflow
`define REVO_FIFO_DEPTH 4

// ------------------------------------------------------------
// serializer words
// ------------------------------------------------------------

// trigger words per revo event
`define REVO_TRG_WORDS 2

// idle pattern and trigger pattern, msb goes out first
`define REVO_WORD_NULL 8'b11000000
`define REVO_WORD_TRG 8'b00111111

// ------------------------------------------------------------
// csr map, one address bit
// ------------------------------------------------------------
`define REVO_ADDR_CTRL 1'b0
`define REVO_ADDR_STATUS 1'b1

`endif

// ==== common/revo_pkg.sv ====
// shared types for the revo trigger encoder
package revo_pkg;

	// ------------------------------------------------------------
	// revo event payload
	// ------------------------------------------------------------

	// width of one queued event, just the marker phase
	localparam int REVO_EVENT_WIDTH = 2;

	// phase index of the marker inside the oversampled word
	// 1000 -> 0, 0100 -> 1, 0010 -> 2, 0001 -> 3
	typedef logic [REVO_EVENT_WIDTH-1:0] revo_phase_t;

	// ------------------------------------------------------------
	// csr data word
	// ------------------------------------------------------------

	// control register, write side
	typedef struct packed {
		logic [29:0] reserved;
		logic        clear_counters;   // self clearing, acts on the write
		logic        enable;
	} revo_ctrl_t;

	// status register, read side
	typedef struct packed {
		logic [4:0]  reserved;
		logic        fifo_empty;
		revo_phase_t phase;
		logic [7:0]  overflow_count;
		logic [15:0] event_count;      // lowest bits of the word
	} revo_status_t;

	// same bus word, decoded per address
	typedef union packed {
		logic [31:0]  raw;
		revo_ctrl_t   ctrl;
		revo_status_t status;
	} revo_csr_word_u;

endpackage

// ==== rtl/revo_phase_detector.sv ====
`timescale 1ns/1ps

module revo_phase_detector (
	input  logic                  local_clock50,
	input  logic                  reset,
	input  logic                  enable,
	input  logic [3:0]            revo_word,
	input  logic                  revo_word_valid,
	output logic                  event_push,
	output revo_pkg::revo_phase_t event_phase,
	output revo_pkg::revo_phase_t phase_select
);

	// captured input word
	logic [3:0]            word_q;
	logic                  word_q_valid;
	// previous accepted word was all zero
	logic                  last_zero;
	// decode of the captured word
	logic                  is_one_hot;
	revo_pkg::revo_phase_t decoded_phase;

	// ------------------------------------------------------------
	// stage 1, capture the oversampled word
	// ------------------------------------------------------------

	// payload only, qualified by word_q_valid
	always_ff @(posedge local_clock50) begin
		word_q <= revo_word;
	end

	// ------------------------------------------------------------
	// one-hot decode
	// ------------------------------------------------------------
	always_comb begin
		is_one_hot = 1'b1;
		decoded_phase = 2'd0;
		case (word_q)
			4'b1000: decoded_phase = 2'd0;
			4'b0100: decoded_phase = 2'd1;
			4'b0010: decoded_phase = 2'd2;
			4'b0001: decoded_phase = 2'd3;
			// zero or more than one bit set, no marker
			default: is_one_hot = 1'b0;
		endcase
	end

	// ------------------------------------------------------------
	// stage 2, edge detect and phase tracking
	// ------------------------------------------------------------
	always_ff @(posedge local_clock50) begin
		if (reset) begin
			word_q_valid <= 1'b0;
			last_zero <= 1'b0;
			event_push <= 1'b0;
			phase_select <= 2'd0;
		end else begin
			word_q_valid <= revo_word_valid;
			// push is a single cycle pulse
			event_push <= 1'b0;
			if (word_q_valid) begin
				last_zero <= (word_q == 4'b0000);
				if (is_one_hot) begin
					// phase follows every marker, enabled or not
					phase_select <= decoded_phase;
					// rising edge of the marker only
					event_push <= last_zero && enable;
				end
			end
		end
	end

	// the pushed phase is the one just latched
	assign event_phase = phase_select;

endmodule

// ==== rtl/revo_event_fifo.sv ====
`timescale 1ns/1ps
`include "revo_config.svh"

module revo_event_fifo (
	input  logic                  local_clock50,
	input  logic                  reset,
	input  logic                  event_push,
	input  revo_pkg::revo_phase_t event_phase,
	input  logic                  event_pop,
	output revo_pkg::revo_phase_t head_phase,
	output logic                  event_empty,
	output logic                  overflow
);

	localparam int DEPTH = `REVO_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// event storage
	revo_pkg::revo_phase_t mem [DEPTH];
	logic [PTR_W-1:0]      wr_ptr;
	logic [PTR_W-1:0]      rd_ptr;
	logic [CNT_W-1:0]      count;
	logic                  full;
	logic                  do_push;
	logic                  do_pop;

	// ------------------------------------------------------------
	// flags and qualified strobes
	// ------------------------------------------------------------
	assign full = (count == CNT_W'(DEPTH));
	assign event_empty = (count == '0);
	assign do_pop = event_pop && !event_empty;
	// a pop in the same cycle frees the slot
	assign do_push = event_push && (!full || do_pop);
	assign head_phase = mem[rd_ptr];

	// storage, no reset
	always_ff @(posedge local_clock50) begin
		if (do_push) begin
			mem[wr_ptr] <= event_phase;
		end
	end

	// ------------------------------------------------------------
	// pointers, count, overflow
	// ------------------------------------------------------------
	always_ff @(posedge local_clock50) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			// dropped push, one cycle pulse
			overflow <= event_push && !do_push;
			if (do_push) begin
				// wrap for any depth
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------

	// the encoder only pops a queued event
	a_no_pop_empty: assert property (@(posedge local_clock50) disable iff (reset)
		event_pop |-> !event_empty);

	// occupancy stays bounded across any push/pop mix
	a_count_bound: assert property (@(posedge local_clock50) disable iff (reset)
		count <= CNT_W'(DEPTH));

endmodule

// ==== rtl/trigger_word_encoder.sv ====
`timescale 1ns/1ps
`include "revo_config.svh"

module trigger_word_encoder (
	input  logic                  local_clock50,
	input  logic                  reset,
	input  logic                  event_empty,
	input  revo_pkg::revo_phase_t head_phase,
	output logic                  event_pop,
	output logic [7:0]            trg_word,
	output revo_pkg::revo_phase_t trg_phase
);

	localparam int CNT_W = $clog2(`REVO_TRG_WORDS + 1);

	// trigger words still to follow the current one
	logic [CNT_W-1:0] remaining;
	logic             busy;

	// ------------------------------------------------------------
	// pop control
	// ------------------------------------------------------------

	// last word of a burst counts as free, so bursts chain
	assign busy = (remaining != '0);
	assign event_pop = !busy && !event_empty;

	// ------------------------------------------------------------
	// burst counter and word output
	// ------------------------------------------------------------
	always_ff @(posedge local_clock50) begin
		if (reset) begin
			remaining <= '0;
			trg_word <= `REVO_WORD_NULL;
		end else if (event_pop) begin
			// first trigger word on the pop edge
			remaining <= CNT_W'(`REVO_TRG_WORDS - 1);
			trg_word <= `REVO_WORD_TRG;
		end else if (busy) begin
			remaining <= remaining - 1'b1;
			trg_word <= `REVO_WORD_TRG;
		end else begin
			// idle pattern
			trg_word <= `REVO_WORD_NULL;
		end
	end

	// phase of the burst in flight, payload only
	always_ff @(posedge local_clock50) begin
		if (event_pop) begin
			trg_phase <= head_phase;
		end
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------

	// a burst runs its full length with no pop inside it
	a_burst_no_pop: assert property (@(posedge local_clock50) disable iff (reset)
		event_pop |=> (trg_word == `REVO_WORD_TRG && !event_pop) [*`REVO_TRG_WORDS - 1]);

endmodule

// ==== rtl/revo_csr.sv ====
`timescale 1ns/1ps
`include "revo_config.svh"

module revo_csr (
	input  logic                  local_clock50,
	input  logic                  reset,
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  logic                  wb_adr,
	input  logic [31:0]           wb_dat_w,
	output logic [31:0]           wb_dat_r,
	output logic                  wb_ack,
	input  logic                  event_push,
	input  logic                  overflow,
	input  revo_pkg::revo_phase_t phase_select,
	input  logic                  event_empty,
	output logic                  enable
);

	// bus word views
	revo_pkg::revo_csr_word_u wr_word;
	revo_pkg::revo_csr_word_u rd_word;
	// counters
	logic [15:0] event_count;
	logic [7:0]  overflow_count;
	// strobes, one per access
	logic        access;
	logic        ctrl_write;
	logic        clear;

	// ------------------------------------------------------------
	// bus decode
	// ------------------------------------------------------------

	// new access only while no ack is out
	assign access = wb_cyc && wb_stb && !wb_ack;
	assign ctrl_write = access && wb_we && (wb_adr == `REVO_ADDR_CTRL);
	assign wr_word.raw = wb_dat_w;
	assign clear = ctrl_write && wr_word.ctrl.clear_counters;

	// read mux through the union views
	always_comb begin
		rd_word.raw = 32'd0;
		if (wb_adr == `REVO_ADDR_STATUS) begin
			rd_word.status.event_count = event_count;
			rd_word.status.overflow_count = overflow_count;
			rd_word.status.phase = phase_select;
			rd_word.status.fifo_empty = event_empty;
		end else begin
			rd_word.ctrl.enable = enable;
		end
	end

	// read data, only looked at during ack
	always_ff @(posedge local_clock50) begin
		if (access && !wb_we) begin
			wb_dat_r <= rd_word.raw;
		end
	end

	// ------------------------------------------------------------
	// ack, control register, counters
	// ------------------------------------------------------------
	always_ff @(posedge local_clock50) begin
		if (reset) begin
			wb_ack <= 1'b0;
			enable <= 1'b0;
			event_count <= 16'd0;
			overflow_count <= 8'd0;
		end else begin
			wb_ack <= access;
			if (ctrl_write) begin
				enable <= wr_word.ctrl.enable;
			end
			// clear wins over a same cycle count
			if (clear) begin
				event_count <= 16'd0;
				overflow_count <= 8'd0;
			end else begin
				// wraps
				if (event_push) begin
					event_count <= event_count + 1'b1;
				end
				// saturates
				if (overflow && overflow_count != 8'hff) begin
					overflow_count <= overflow_count + 1'b1;
				end
			end
		end
	end

	// master holds the strobe until it sees the ack
	a_ack_in_stb: assert property (@(posedge local_clock50) disable iff (reset)
		wb_ack |-> wb_stb);

endmodule

// ==== rtl/revo_encoder_top.sv ====
`timescale 1ns/1ps

module revo_encoder_top (
	input  logic                  local_clock50,
	input  logic                  reset,
	input  logic [3:0]            revo_word,
	input  logic                  revo_word_valid,
	output logic [7:0]            trg_word,
	output revo_pkg::revo_phase_t trg_phase,
	output revo_pkg::revo_phase_t phase_select,
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  logic                  wb_adr,
	input  logic [31:0]           wb_dat_w,
	output logic [31:0]           wb_dat_r,
	output logic                  wb_ack
);

	// detector to fifo
	logic                  event_push;
	revo_pkg::revo_phase_t event_phase;
	// fifo to encoder
	logic                  event_pop;
	logic                  event_empty;
	revo_pkg::revo_phase_t head_phase;
	// status and control
	logic                  overflow;
	logic                  enable;

	// ------------------------------------------------------------
	// revo producer, buffer, trigger consumer
	// ------------------------------------------------------------
	revo_phase_detector detector_i (
		.local_clock50(local_clock50), .reset(reset), .enable(enable),
		.revo_word(revo_word), .revo_word_valid(revo_word_valid),
		.event_push(event_push), .event_phase(event_phase),
		.phase_select(phase_select)
	);

	revo_event_fifo fifo_i (
		.local_clock50(local_clock50), .reset(reset),
		.event_push(event_push), .event_phase(event_phase), .event_pop(event_pop),
		.head_phase(head_phase), .event_empty(event_empty), .overflow(overflow)
	);

	trigger_word_encoder encoder_i (
		.local_clock50(local_clock50), .reset(reset),
		.event_empty(event_empty), .head_phase(head_phase), .event_pop(event_pop),
		.trg_word(trg_word), .trg_phase(trg_phase)
	);

	// ------------------------------------------------------------
	// wishbone register slave
	// ------------------------------------------------------------
	revo_csr csr_i (
		.local_clock50(local_clock50), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.event_push(event_push), .overflow(overflow),
		.phase_select(phase_select), .event_empty(event_empty),
		.enable(enable)
	);

endmodule

// ==== test/revo_encoder_tb.sv ====
`timescale 1ns/1ps
`include "revo_config.svh"

module revo_encoder_tb;

	localparam int NUM_ROWS = 33;
	localparam int NUM_TESTS = 6;
	localparam int MAX_GAP = 3;
	// idle gaps, drain slack and csr accesses of one test
	localparam int TEST_OVERHEAD = 2 * MAX_GAP + 16;
	localparam int BURST_ALLOWANCE = NUM_ROWS * `REVO_TRG_WORDS;
	localparam int TIMEOUT_CYCLES = 4 * (NUM_ROWS + NUM_TESTS * TEST_OVERHEAD) + BURST_ALLOWANCE;

	// one stimulus row, phase is phase_select once the row is taken
	typedef struct packed {
		logic [3:0] word;
		logic       valid;
		logic [1:0] phase;
		logic       marker;
	} row_t;

	localparam row_t ROWS [NUM_ROWS] = '{
		// rows 0-9, each one-hot word after a zero word, then 0110
		'{4'b0000, 1'b1, 2'd0, 1'b0}, '{4'b1000, 1'b1, 2'd0, 1'b1},
		'{4'b0000, 1'b1, 2'd0, 1'b0}, '{4'b0100, 1'b1, 2'd1, 1'b1},
		'{4'b0000, 1'b1, 2'd1, 1'b0}, '{4'b0010, 1'b1, 2'd2, 1'b1},
		'{4'b0000, 1'b1, 2'd2, 1'b0}, '{4'b0001, 1'b1, 2'd3, 1'b1},
		'{4'b0110, 1'b1, 2'd3, 1'b0}, '{4'b0000, 1'b1, 2'd3, 1'b0},
		// rows 10-15, repeated marker and an invalid word
		'{4'b0100, 1'b1, 2'd1, 1'b1}, '{4'b0100, 1'b1, 2'd1, 1'b0},
		'{4'b1000, 1'b0, 2'd1, 1'b0}, '{4'b0000, 1'b1, 2'd1, 1'b0},
		'{4'b0010, 1'b1, 2'd2, 1'b1}, '{4'b0000, 1'b1, 2'd2, 1'b0},
		// rows 16-20, run with enable low
		'{4'b0000, 1'b1, 2'd2, 1'b0}, '{4'b0001, 1'b1, 2'd3, 1'b1},
		'{4'b0000, 1'b1, 2'd3, 1'b0}, '{4'b1000, 1'b1, 2'd0, 1'b1},
		'{4'b0000, 1'b1, 2'd0, 1'b0},
		// rows 21-32, six edges as fast as the line allows
		'{4'b0000, 1'b1, 2'd0, 1'b0}, '{4'b1000, 1'b1, 2'd0, 1'b1},
		'{4'b0000, 1'b1, 2'd0, 1'b0}, '{4'b0100, 1'b1, 2'd1, 1'b1},
		'{4'b0000, 1'b1, 2'd1, 1'b0}, '{4'b0010, 1'b1, 2'd2, 1'b1},
		'{4'b0000, 1'b1, 2'd2, 1'b0}, '{4'b0001, 1'b1, 2'd3, 1'b1},
		'{4'b0000, 1'b1, 2'd3, 1'b0}, '{4'b1000, 1'b1, 2'd0, 1'b1},
		'{4'b0000, 1'b1, 2'd0, 1'b0}, '{4'b0100, 1'b1, 2'd1, 1'b1}
	};

	logic                  local_clock50;
	logic                  reset;
	logic [3:0]            revo_word;
	logic                  revo_word_valid;
	logic [7:0]            trg_word;
	revo_pkg::revo_phase_t trg_phase;
	revo_pkg::revo_phase_t phase_select;
	logic                  wb_cyc;
	logic                  wb_stb;
	logic                  wb_we;
	logic                  wb_adr;
	logic [31:0]           wb_dat_w;
	logic [31:0]           wb_dat_r;
	logic                  wb_ack;

	// reference model state, times in drive steps
	int step;
	int next_free;
	int exp_events;
	int exp_accepted;
	int exp_dropped;
	int start_q[$];
	logic model_enable;
	revo_pkg::revo_phase_t model_phase;
	revo_pkg::revo_phase_t burst_phase_q[$];
	revo_pkg::revo_phase_t phase_chk_q[$];
	// monitor state
	int trg_seen;
	int burst_pos;
	revo_pkg::revo_phase_t burst_phase;
	// bookkeeping
	int errors;
	int test_err_base;
	int tests_run;
	int tests_failed;
	int cycle_count;
	revo_pkg::revo_csr_word_u rd_word;

	revo_encoder_top dut_i (
		.local_clock50(local_clock50), .reset(reset),
		.revo_word(revo_word), .revo_word_valid(revo_word_valid),
		.trg_word(trg_word), .trg_phase(trg_phase), .phase_select(phase_select),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
	);

	initial begin
		local_clock50 = 1'b0;
		forever #50 local_clock50 = ~local_clock50;
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("error: %s", msg);
		errors++;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_err_base) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d check(s) wrong", name, errors - test_err_base);
		end
		test_err_base = errors;
	endtask

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------

	// event reaches the fifo two steps after capture, burst one step later
	task automatic schedule_event(input revo_pkg::revo_phase_t ph);
		int arrive;
		int waiting;
		int start;
		arrive = step + 2;
		waiting = 0;
		// still queued at the arrival edge, a pop on that edge frees its slot
		foreach (start_q[i]) begin
			if (start_q[i] > arrive) begin
				waiting++;
			end
		end
		exp_events++;
		if (waiting >= `REVO_FIFO_DEPTH) begin
			exp_dropped++;
		end else begin
			// bursts chain back to back
			start = (step + 3 > next_free) ? step + 3 : next_free;
			next_free = start + `REVO_TRG_WORDS;
			start_q.push_back(start);
			burst_phase_q.push_back(ph);
			exp_accepted++;
		end
	endtask

	// ------------------------------------------------------------
	// revo line stimulus
	// ------------------------------------------------------------
	task automatic drive_step(input logic [3:0] word, input logic valid,
		input revo_pkg::revo_phase_t ph, input logic marker);
		@(posedge local_clock50);
		#1;
		// phase_select lags a driven word by two edges
		if (phase_chk_q.size() >= 2) begin
			check_value("phase_select", phase_select, phase_chk_q.pop_front());
		end
		revo_word = word;
		revo_word_valid = valid;
		phase_chk_q.push_back(ph);
		model_phase = ph;
		if (marker && model_enable) begin
			schedule_event(ph);
		end
		step++;
	endtask

	task automatic idle_step();
		drive_step(4'b0000, 1'b1, model_phase, 1'b0);
	endtask

	task automatic run_rows(input int first, input int last);
		row_t r;
		for (int i = first; i <= last; i++) begin
			r = ROWS[i];
			drive_step(r.word, r.valid, r.phase, r.marker);
		end
	endtask

	task automatic idle_gap();
		int n;
		n = $urandom_range(MAX_GAP, 0);
		repeat (n) idle_step();
	endtask

	// until every queued burst has left the serializer port
	task automatic drain();
		repeat (3) idle_step();
		while (step < next_free + 4) begin
			idle_step();
		end
	endtask

	// ------------------------------------------------------------
	// wishbone master
	// ------------------------------------------------------------
	task automatic wb_access(input logic we, input logic adr, input logic [31:0] wdata,
		output logic [31:0] rdata);
		int waited;
		@(posedge local_clock50);
		#1;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		waited = 0;
		do begin
			@(posedge local_clock50);
			#1;
			waited++;
		end while (!wb_ack && waited < 8);
		rdata = wb_dat_r;
		if (!wb_ack) begin
			note_failure("wishbone access got no ack");
		end else begin
			check_value("wb_ack latency", waited, 1);
		end
		// strobe held through the ack cycle
		@(posedge local_clock50);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		if (wb_ack) begin
			note_failure("wb_ack stayed high for more than one cycle");
		end
	endtask

	task automatic write_ctrl(input logic en, input logic clear);
		logic [31:0] unused;
		wb_access(1'b1, `REVO_ADDR_CTRL, {30'd0, clear, en}, unused);
		model_enable = en;
	endtask

	task automatic check_status(input logic exp_empty);
		logic [31:0] data;
		wb_access(1'b0, `REVO_ADDR_STATUS, 32'd0, data);
		rd_word.raw = data;
		check_value("event_count", rd_word.status.event_count, exp_events & 16'hffff);
		check_value("overflow_count", rd_word.status.overflow_count,
			(exp_dropped > 255) ? 255 : exp_dropped);
		check_value("status phase", rd_word.status.phase, model_phase);
		check_value("fifo_empty", rd_word.status.fifo_empty, exp_empty);
	endtask

	task automatic check_bursts();
		check_value("trigger words", trg_seen, exp_accepted * `REVO_TRG_WORDS);
	endtask

	// ------------------------------------------------------------
	// serializer port monitor
	// ------------------------------------------------------------
	always @(negedge local_clock50) begin
		if (!reset) begin
			if (trg_word == `REVO_WORD_TRG) begin
				if (burst_pos == 0) begin
					if (burst_phase_q.size() == 0) begin
						note_failure("trigger word with no event behind it");
					end else begin
						burst_phase = burst_phase_q.pop_front();
					end
				end
				check_value("trg_phase", trg_phase, burst_phase);
				burst_pos = (burst_pos + 1) % `REVO_TRG_WORDS;
				trg_seen++;
			end else begin
				check_value("trg_word", trg_word, `REVO_WORD_NULL);
				if (burst_pos != 0) begin
					note_failure("trigger burst ended early");
				end
				burst_pos = 0;
			end
		end
	end

	// run limit
	always @(posedge local_clock50) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout, run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failures found");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------
	initial begin
		void'($urandom(32'h21a7));
		reset = 1'b1;
		revo_word = 4'b0000;
		revo_word_valid = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 1'b0;
		wb_dat_w = 32'd0;
		step = 0;
		next_free = 0;
		exp_events = 0;
		exp_accepted = 0;
		exp_dropped = 0;
		model_enable = 1'b0;
		model_phase = 2'd0;
		trg_seen = 0;
		burst_pos = 0;
		burst_phase = 2'd0;
		errors = 0;
		test_err_base = 0;
		tests_run = 0;
		tests_failed = 0;
		cycle_count = 0;
		repeat (10) @(posedge local_clock50);
		#1;
		reset = 1'b0;

		// registers out of reset
		check_status(1'b1);
		wb_access(1'b0, `REVO_ADDR_CTRL, 32'd0, rd_word.raw);
		check_value("enable", rd_word.ctrl.enable, 1'b0);
		end_test("csr_reset");

		write_ctrl(1'b1, 1'b0);
		idle_gap();
		run_rows(0, 9);
		drain();
		check_bursts();
		check_status(1'b1);
		end_test("phase_decode");

		idle_gap();
		run_rows(10, 15);
		drain();
		check_bursts();
		check_status(1'b1);
		end_test("one_event_per_edge");

		// phase still tracked, nothing queued
		write_ctrl(1'b0, 1'b0);
		idle_gap();
		run_rows(16, 20);
		drain();
		check_bursts();
		check_status(1'b1);
		end_test("disabled");

		write_ctrl(1'b1, 1'b0);
		idle_gap();
		run_rows(21, 32);
		drain();
		check_bursts();
		check_status(1'b1);
		end_test("overflow");

		// both counters back to zero
		write_ctrl(1'b1, 1'b1);
		exp_events = 0;
		exp_dropped = 0;
		check_status(1'b1);
		end_test("clear_counters");

		$display("%0d tests run, %0d failed, %0d wrong checks", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== revo_encoder_top.f ====
+incdir+common
common/revo_pkg.sv
rtl/revo_phase_detector.sv
rtl/revo_event_fifo.sv
rtl/trigger_word_encoder.sv
rtl/revo_csr.sv
rtl/revo_encoder_top.sv
test/revo_encoder_tb.sv

// ==== Makefile ====
# Verilator build and run of the revo trigger encoder testbench

TB_TOP = revo_encoder_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		-f revo_encoder_top.f --top-module $(TB_TOP) -o $(TB_TOP)
	@out="$$(./obj_dir/$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
